// ==== compile.f ====
verilog/edgePkg.sv
verilog/regFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/hazardUnit.sv
verilog/edgeCore.sv
dv/clockGen.sv
dv/edgeCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the core with its testbench under Verilator and run the simulation

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module edgeCoreTb -f compile.f -o edgeCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/edgeCoreSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

# The verdict comes from the log, the exit status backs it up
if grep -q "TB FAILED" "$logFile"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "Simulator exited with status $runStatus"
  exit 1
fi
echo "Simulation finished cleanly"
exit 0

// ==== dv/edgeCoreTb.sv ====
module edgeCoreTb import edgePkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // One row of the expected store sequence
  typedef struct packed {
    wordT    addr;
    wordT    data;
    memSizeT size;
  } storeRowT;

  localparam wordT bootPc        = 32'h0000_0000;
  localparam int   progLen       = 54;
  localparam int   numStores     = 19;
  localparam int   timeoutCycles = progLen * 40;
  localparam int   drainCycles   = 12;

  logic    clk, rstN;
  wordT    pc, instr, dataAddr, writeData, readData;
  logic    memWrite;
  memSizeT memSize;
  logic    dataStall = 1'b0;

  wordT     progMem [64];
  wordT     dataMem [256];
  storeRowT expectedStores [numStores];
  int       storeCount = 0;
  int       cycleCount = 0;
  integer   seed = 32'hba56_8c46;

  clockGen #(.halfPeriodNs(2), .resetCycles(4)) u_clockGen (.clk, .rstN);

  edgeCore #(.resetPc(bootPc)) u_edgeCore (
    .clk, .rstN, .pc, .instr, .dataAddr, .writeData, .memWrite, .memSize,
    .readData, .dataStall
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////////////////////////////////////////

  // Fetch outside the program space returns sll $0,$0,0 which does nothing
  assign instr    = (pc[31:8] == '0) ? progMem[pc[7:2]] : '0;
  assign readData = dataMem[dataAddr[9:2]];

  // Stores land at the falling edge of the cycle that accepts them
  always @(negedge clk) begin
    if (rstN && memWrite && !dataStall) begin
      if (memSize == MEM_WORD) begin
        dataMem[dataAddr[9:2]] <= writeData;
      end else begin
        dataMem[dataAddr[9:2]][{dataAddr[1:0], 3'b000} +: 8] <=
          writeData[{dataAddr[1:0], 3'b000} +: 8];
      end
      storeCount <= storeCount + 1;
    end
  end

  // About one cycle in four holds the data port
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataStall <= 1'b0;
    end else begin
      dataStall <= (($random(seed) & 3) == 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic stopWithFailure(string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic checkPc(wordT expPc);
    if (pc !== expPc) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: pc is %h, expected %h",
                                $time, pc, expPc));
    end
  endtask

  task automatic checkMemWrite(logic expWrite);
    if (memWrite !== expWrite) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: memWrite is %b, expected %b",
                                $time, memWrite, expWrite));
    end
  endtask

  // Byte stores are judged on the lane their address selects
  task automatic checkStore(wordT expAddr, wordT expData, memSizeT expSize, int row);
    logic [7:0] laneByte;
    laneByte = writeData[{expAddr[1:0], 3'b000} +: 8];
    if (dataAddr !== expAddr) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: store %0d address is %h, expected %h",
                                $time, row, dataAddr, expAddr));
    end else if (memSize !== expSize) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: store %0d size is %0d, expected %0d",
                                $time, row, memSize, expSize));
    end else if (expSize == MEM_WORD && writeData !== expData) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: store %0d data is %h, expected %h",
                                $time, row, writeData, expData));
    end else if (expSize == MEM_BYTE && laneByte !== expData[7:0]) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: store %0d byte is %h, expected %h",
                                $time, row, laneByte, expData[7:0]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders and tables
  ////////////////////////////////////////////////////////////////////////////

  function automatic wordT encodeR(regAddrT rs, regAddrT rt, regAddrT rd,
                                   logic [4:0] shamt, funcT fn);
    return {OP_SPECIAL, rs, rt, rd, shamt, fn};
  endfunction

  function automatic wordT encodeI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wordT encodeJ(opcodeT op, logic [25:0] index);
    return {op, index};
  endfunction

  task automatic loadProgram();
    progMem = '{default: '0};
    // Base pointer in $1 and two operands, one of them negative
    progMem[0]  = encodeI(OP_ADDI, 5'd0, 5'd1, 16'h0100);
    progMem[1]  = encodeI(OP_ADDI, 5'd0, 5'd2, 16'h0007);
    progMem[2]  = encodeI(OP_ADDI, 5'd0, 5'd3, 16'hfffd);
    // ALU ops straight after their producers, so forwarding is exercised
    progMem[3]  = encodeR(5'd2, 5'd3, 5'd4, 5'd0, FN_ADD);
    progMem[4]  = encodeI(OP_SW, 5'd1, 5'd4, 16'd0);
    progMem[5]  = encodeR(5'd2, 5'd3, 5'd5, 5'd0, FN_SUB);
    progMem[6]  = encodeI(OP_SW, 5'd1, 5'd5, 16'd4);
    progMem[7]  = encodeR(5'd2, 5'd3, 5'd6, 5'd0, FN_AND);
    progMem[8]  = encodeR(5'd2, 5'd3, 5'd7, 5'd0, FN_OR);
    progMem[9]  = encodeI(OP_SW, 5'd1, 5'd6, 16'd8);
    progMem[10] = encodeI(OP_SW, 5'd1, 5'd7, 16'd12);
    progMem[11] = encodeR(5'd3, 5'd2, 5'd8, 5'd0, FN_SLT);
    progMem[12] = encodeR(5'd2, 5'd3, 5'd9, 5'd0, FN_SLT);
    progMem[13] = encodeI(OP_SW, 5'd1, 5'd8, 16'd16);
    progMem[14] = encodeI(OP_SW, 5'd1, 5'd9, 16'd20);
    progMem[15] = encodeR(5'd0, 5'd2, 5'd10, 5'd4, FN_SLL);
    progMem[16] = encodeR(5'd0, 5'd3, 5'd11, 5'd28, FN_SRL);
    progMem[17] = encodeI(OP_SW, 5'd1, 5'd10, 16'd24);
    progMem[18] = encodeI(OP_SW, 5'd1, 5'd11, 16'd28);
    // lui then ori with bit 15 set, which must not sign extend
    progMem[19] = encodeI(OP_LUI, 5'd0, 5'd12, 16'h8765);
    progMem[20] = encodeI(OP_ORI, 5'd12, 5'd12, 16'ha987);
    progMem[21] = encodeI(OP_SW, 5'd1, 5'd12, 16'd32);
    // A write to $0 is dropped and never forwarded
    progMem[22] = encodeI(OP_ADDI, 5'd0, 5'd0, 16'd5);
    progMem[23] = encodeR(5'd0, 5'd2, 5'd13, 5'd0, FN_ADD);
    progMem[24] = encodeI(OP_SW, 5'd1, 5'd13, 16'd36);
    progMem[25] = encodeI(OP_SW, 5'd1, 5'd0, 16'd40);
    // Load followed directly by its user
    progMem[26] = encodeI(OP_LW, 5'd1, 5'd14, 16'd0);
    progMem[27] = encodeI(OP_ADDI, 5'd14, 5'd15, 16'd1);
    progMem[28] = encodeI(OP_SW, 5'd1, 5'd15, 16'd44);
    // Byte 0xa9 sits on lane 1 of the word at 0x120
    progMem[29] = encodeI(OP_LB, 5'd1, 5'd16, 16'd33);
    progMem[30] = encodeI(OP_LBU, 5'd1, 5'd17, 16'd33);
    progMem[31] = encodeI(OP_SW, 5'd1, 5'd16, 16'd48);
    progMem[32] = encodeI(OP_SW, 5'd1, 5'd17, 16'd52);
    progMem[33] = encodeI(OP_SB, 5'd1, 5'd2, 16'd57);
    progMem[34] = encodeI(OP_LBU, 5'd1, 5'd18, 16'd57);
    progMem[35] = encodeI(OP_SW, 5'd1, 5'd18, 16'd60);
    // Branches, taken and not, each followed by stores that reveal a wrong path
    progMem[36] = encodeI(OP_BEQ, 5'd2, 5'd2, 16'd2);
    progMem[37] = encodeI(OP_SW, 5'd1, 5'd2, 16'd64);
    progMem[38] = encodeI(OP_SW, 5'd1, 5'd3, 16'd64);
    progMem[39] = encodeI(OP_BNE, 5'd2, 5'd2, 16'd1);
    progMem[40] = encodeI(OP_SW, 5'd1, 5'd2, 16'd68);
    progMem[41] = encodeI(OP_BEQ, 5'd2, 5'd3, 16'd1);
    progMem[42] = encodeI(OP_SW, 5'd1, 5'd3, 16'd72);
    progMem[43] = encodeI(OP_BNE, 5'd2, 5'd3, 16'd2);
    progMem[44] = encodeI(OP_SW, 5'd1, 5'd2, 16'd76);
    progMem[45] = encodeI(OP_SW, 5'd1, 5'd2, 16'd80);
    progMem[46] = encodeJ(OP_J, 26'd49);
    progMem[47] = encodeI(OP_SW, 5'd1, 5'd2, 16'd84);
    progMem[48] = encodeI(OP_SW, 5'd1, 5'd2, 16'd88);
    progMem[49] = encodeJ(OP_JAL, 26'd52);
    progMem[50] = encodeI(OP_SW, 5'd1, 5'd2, 16'd92);
    progMem[51] = encodeI(OP_SW, 5'd1, 5'd2, 16'd96);
    progMem[52] = encodeI(OP_SW, 5'd1, 5'd31, 16'd100);
    // Park on a jump to itself
    progMem[53] = encodeJ(OP_J, 26'd53);
  endtask

  // Address, data and size of every store in program order
  task automatic loadExpectedStores();
    expectedStores[0]  = '{32'h0000_0100, 32'h0000_0004, MEM_WORD};
    expectedStores[1]  = '{32'h0000_0104, 32'h0000_000a, MEM_WORD};
    expectedStores[2]  = '{32'h0000_0108, 32'h0000_0005, MEM_WORD};
    expectedStores[3]  = '{32'h0000_010c, 32'hffff_ffff, MEM_WORD};
    expectedStores[4]  = '{32'h0000_0110, 32'h0000_0001, MEM_WORD};
    expectedStores[5]  = '{32'h0000_0114, 32'h0000_0000, MEM_WORD};
    expectedStores[6]  = '{32'h0000_0118, 32'h0000_0070, MEM_WORD};
    expectedStores[7]  = '{32'h0000_011c, 32'h0000_000f, MEM_WORD};
    expectedStores[8]  = '{32'h0000_0120, 32'h8765_a987, MEM_WORD};
    expectedStores[9]  = '{32'h0000_0124, 32'h0000_0007, MEM_WORD};
    expectedStores[10] = '{32'h0000_0128, 32'h0000_0000, MEM_WORD};
    expectedStores[11] = '{32'h0000_012c, 32'h0000_0005, MEM_WORD};
    expectedStores[12] = '{32'h0000_0130, 32'hffff_ffa9, MEM_WORD};
    expectedStores[13] = '{32'h0000_0134, 32'h0000_00a9, MEM_WORD};
    expectedStores[14] = '{32'h0000_0139, 32'h0000_0007, MEM_BYTE};
    expectedStores[15] = '{32'h0000_013c, 32'h0000_0007, MEM_WORD};
    expectedStores[16] = '{32'h0000_0144, 32'h0000_0007, MEM_WORD};
    expectedStores[17] = '{32'h0000_0148, 32'hffff_fffd, MEM_WORD};
    // Link value of the jal at 0xc4
    expectedStores[18] = '{32'h0000_0164, 32'h0000_00c8, MEM_WORD};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  // Advances to the next falling edge where the data port accepts a store
  task automatic waitForStore();
    @(negedge clk);
    while (!(memWrite === 1'b1 && dataStall === 1'b0)) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      stopWithFailure($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                                cycleCount, storeCount, numStores));
    end
  end

  initial begin
    loadProgram();
    loadExpectedStores();
    // Every word of the fill differs so a stray load cannot look right by chance
    for (int i = 0; i < 256; i++) begin
      dataMem[i] = (wordT'(i) * 32'h9e37_79b9) ^ 32'h0f0f_0f0f;
    end

    // Reset holds the fetch address and keeps the store strobe quiet
    // Sampling starts on the first falling edge after a rising edge, when pc
    // has settled on its reset value
    @(posedge clk);
    @(negedge clk);
    while (!rstN) begin
      checkPc(bootPc);
      checkMemWrite(1'b0);
      @(negedge clk);
    end
    checkPc(bootPc);
    checkMemWrite(1'b0);

    for (int row = 0; row < numStores; row++) begin
      waitForStore();
      checkStore(expectedStores[row].addr, expectedStores[row].data,
                 expectedStores[row].size, row);
    end

    // Any store from a wrong path would still show up during the drain
    repeat (drainCycles) @(negedge clk);
    if (storeCount != numStores) begin
      stopWithFailure($sformatf("Mismatch at %0d ns: saw %0d stores, expected %0d",
                                $time, storeCount, numStores));
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== dv/clockGen.sv ====
module clockGen #(
  parameter int halfPeriodNs = 2,
  parameter int resetCycles  = 4
) (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, 4 ns period with the default half period
  initial begin
    clk = 1'b0;
    forever #(halfPeriodNs) clk = ~clk;
  end

  // Reset is released on a rising edge so the core sees it low on every edge before
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

// ==== verilog/edgeCore.sv ====
module edgeCore import edgePkg::*; #(
  parameter wordT resetPc = 32'h0000_0000
) (
  input  logic    clk,
  input  logic    rstN,
  output wordT    pc,
  input  wordT    instr,
  output wordT    dataAddr,
  output wordT    writeData,
  output logic    memWrite,
  output memSizeT memSize,
  input  wordT    readData,
  input  logic    dataStall
);

  ifIdT    ifId;
  idExT    idEx;
  exMemT   exMem;
  pcSrcT   pcSrc;
  wordT    branchTarget, jumpTarget;
  regAddrT readAddrA, readAddrB, wbWriteReg;
  wordT    readValueA, readValueB, wbResult;
  logic    wbRegWrite;
  logic    stallF, stallD, flushD, flushE, flushM;
  fwdSelT  fwdA, fwdB;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////////////////////

  fetchStage #(.resetPc(resetPc)) u_fetchStage (
    .clk, .rstN, .instr, .pcSrc, .branchTarget, .jumpTarget,
    .stallF, .stallD, .flushD, .dataStall, .pc, .ifId
  );

  decodeStage u_decodeStage (
    .clk, .rstN, .ifId, .readValueA, .readValueB, .readAddrA, .readAddrB,
    .stallD, .flushE, .dataStall, .idEx
  );

  // Writes come from the writeback stage and reads serve decode
  regFile u_regFile (
    .clk, .rstN, .readAddrA, .readAddrB,
    .writeAddr(wbWriteReg), .writeEn(wbRegWrite), .writeValue(wbResult),
    .readValueA, .readValueB
  );

  executeStage u_executeStage (
    .clk, .rstN, .idEx, .fwdA, .fwdB, .wbResult, .flushM, .dataStall,
    .exMem, .memAluResult()
  );

  memWbStage u_memWbStage (
    .clk, .rstN, .exMem, .readData, .dataStall, .pcSrc, .branchTarget,
    .jumpTarget, .writeReg(wbWriteReg), .regWrite(wbRegWrite), .wbResult
  );

  // Loads always write rt, so the execute destination for load-use is rt
  hazardUnit u_hazardUnit (
    .idRs(readAddrA), .idRt(readAddrB),
    .exRs(idEx.rs), .exRt(idEx.rt),
    .exWriteReg(idEx.rt), .exMemRead(idEx.ctrl.memRead),
    .memWriteReg(exMem.writeReg), .memRegWrite(exMem.valid && exMem.ctrl.regWrite),
    .wbWriteReg, .wbRegWrite, .pcSrc,
    .stallF, .stallD, .flushD, .flushE, .flushM, .fwdA, .fwdB
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data memory port
  ////////////////////////////////////////////////////////////////////////////

  // All of these come straight from the EX/MEM register, so they stay put
  // for as long as dataStall holds that register
  assign dataAddr = exMem.aluResult;
  assign memWrite = exMem.valid && exMem.ctrl.memWrite;
  assign memSize  = exMem.ctrl.memSize;

  // A byte store moves its byte onto the lane picked by the low address bits
  assign writeData = (exMem.ctrl.memSize == MEM_BYTE) ?
                     (wordT'(exMem.storeData[7:0]) << {exMem.aluResult[1:0], 3'b000}) :
                     exMem.storeData;

endmodule

// ==== verilog/hazardUnit.sv ====
module hazardUnit import edgePkg::*; (
  input  regAddrT idRs,
  input  regAddrT idRt,
  input  regAddrT exRs,
  input  regAddrT exRt,
  input  regAddrT exWriteReg,
  input  logic    exMemRead,
  input  regAddrT memWriteReg,
  input  logic    memRegWrite,
  input  regAddrT wbWriteReg,
  input  logic    wbRegWrite,
  input  pcSrcT   pcSrc,
  output logic    stallF,
  output logic    stallD,
  output logic    flushD,
  output logic    flushE,
  output logic    flushM,
  output fwdSelT  fwdA,
  output fwdSelT  fwdB
);

  logic loadUse, redirect;

  // The memory stage holds the younger result, so it is checked first
  // Register 0 is never forwarded because it always reads as zero
  function automatic fwdSelT pickFwd(regAddrT src);
    if (src != '0 && memRegWrite && memWriteReg == src) begin
      return FWD_MEM;
    end else if (src != '0 && wbRegWrite && wbWriteReg == src) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    fwdA = pickFwd(exRs);
    fwdB = pickFwd(exRt);
  end

  // A load in execute whose target is read by the instruction in decode
  // costs one bubble, after which its value comes from writeback
  assign loadUse = exMemRead && exWriteReg != '0 &&
                   (exWriteReg == idRs || exWriteReg == idRt);

  // A taken branch or jump drops the three younger instructions
  assign redirect = (pcSrc != PC_PLUS4);

  assign stallF = loadUse;
  assign stallD = loadUse;
  assign flushD = redirect;
  assign flushE = loadUse || redirect;
  assign flushM = redirect;

endmodule

// ==== verilog/memWbStage.sv ====
module memWbStage import edgePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  exMemT   exMem,
  input  wordT    readData,
  input  logic    dataStall,
  output pcSrcT   pcSrc,
  output wordT    branchTarget,
  output wordT    jumpTarget,
  output regAddrT writeReg,
  output logic    regWrite,
  output wordT    wbResult
);

  memWbT      memWb;
  logic [7:0] loadByte;
  wordT       loadValue;

  // Branches and jumps resolve here, in the memory stage
  // bne is taken exactly when beq would not be
  always_comb begin
    if (exMem.valid && exMem.ctrl.jump) begin
      pcSrc = PC_JUMP;
    end else if (exMem.valid && exMem.ctrl.branch && (exMem.zero ^ exMem.ctrl.branchNe)) begin
      pcSrc = PC_BRANCH;
    end else begin
      pcSrc = PC_PLUS4;
    end
  end

  assign branchTarget = exMem.branchTarget;
  assign jumpTarget   = exMem.jumpTarget;

  // MEM/WB register, which takes a bubble on every stalled cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWb <= '0;
    end else if (dataStall) begin
      memWb <= '0;
    end else begin
      memWb.ctrl      <= exMem.ctrl;
      memWb.writeReg  <= exMem.writeReg;
      memWb.aluResult <= exMem.aluResult;
      memWb.readData  <= readData;
      memWb.byteLane  <= exMem.aluResult[1:0];
      memWb.pcPlus4   <= exMem.pcPlus4;
      memWb.valid     <= exMem.valid;
    end
  end

  // Byte loads pick their lane in little-endian order
  assign loadByte = memWb.readData[{memWb.byteLane, 3'b000} +: 8];

  always_comb begin
    if (memWb.ctrl.memSize == MEM_WORD) begin
      loadValue = memWb.readData;
    end else if (memWb.ctrl.loadSigned) begin
      loadValue = {{24{loadByte[7]}}, loadByte};
    end else begin
      loadValue = {24'h000000, loadByte};
    end
  end

  always_comb begin
    case (memWb.ctrl.resultSel)
      RES_MEM:  wbResult = loadValue;
      RES_LINK: wbResult = memWb.pcPlus4;
      default:  wbResult = memWb.aluResult;
    endcase
  end

  assign writeReg = memWb.writeReg;
  assign regWrite = memWb.valid && memWb.ctrl.regWrite;

endmodule

// ==== verilog/executeStage.sv ====
module executeStage import edgePkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  idExT   idEx,
  input  fwdSelT fwdA,
  input  fwdSelT fwdB,
  input  wordT   wbResult,
  input  logic   flushM,
  input  logic   dataStall,
  output exMemT  exMem,
  output wordT   memAluResult
);

  wordT    liveA, liveB, heldA, heldB, srcA, regB, srcB;
  wordT    aluValue, exResult;
  regAddrT writeReg;
  logic    frozen;

  function automatic wordT pickOperand(fwdSelT sel, wordT regValue, wordT wbValue,
                                       wordT memValue);
    case (sel)
      FWD_WB:  return wbValue;
      FWD_MEM: return memValue;
      default: return regValue;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////////////////////

  assign memAluResult = exMem.aluResult;

  assign liveA = pickOperand(fwdA, idEx.rsValue, wbResult, memAluResult);
  assign liveB = pickOperand(fwdB, idEx.rtValue, wbResult, memAluResult);

  // Writeback turns into a bubble during a data stall, which would take a
  // forwarded value away from the instruction frozen here
  // The operands seen on the first stalled cycle are kept until it moves on
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frozen <= 1'b0;
    end else begin
      frozen <= dataStall;
    end
  end

  always_ff @(posedge clk) begin
    if (dataStall && !frozen) begin
      heldA <= liveA;
      heldB <= liveB;
    end
  end

  assign srcA = frozen ? heldA : liveA;
  assign regB = frozen ? heldB : liveB;
  assign srcB = idEx.ctrl.aluSrcImm ? idEx.imm : regB;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and shifter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (idEx.ctrl.aluOp)
      ALU_SUB: aluValue = srcA - srcB;
      ALU_AND: aluValue = srcA & srcB;
      ALU_OR:  aluValue = srcA | srcB;
      ALU_SLT: aluValue = {31'b0, $signed(srcA) < $signed(srcB)};
      // lui puts the immediate in the upper half and clears the rest
      ALU_LUI: aluValue = {srcB[15:0], 16'h0000};
      default: aluValue = srcA + srcB;
    endcase
  end

  // Shifts take the rt operand and the shamt field of the instruction
  always_comb begin
    case (idEx.ctrl.shiftOp)
      SHIFT_SLL: exResult = regB << idEx.shamt;
      SHIFT_SRL: exResult = regB >> idEx.shamt;
      default:   exResult = aluValue;
    endcase
  end

  // jal always links through register 31
  assign writeReg = idEx.ctrl.link ? LINK_REG : idEx.ctrl.regDst ? idEx.rd : idEx.rt;

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= '0;
    end else if (!dataStall) begin
      if (flushM) begin
        exMem <= '0;
      end else begin
        exMem.ctrl         <= idEx.ctrl;
        exMem.writeReg     <= writeReg;
        exMem.aluResult    <= exResult;
        exMem.storeData    <= regB;
        exMem.branchTarget <= idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};
        exMem.jumpTarget   <= {idEx.pcPlus4[31:28], idEx.jumpIndex, 2'b00};
        exMem.zero         <= (aluValue == '0);
        exMem.pcPlus4      <= idEx.pcPlus4;
        exMem.valid        <= idEx.valid;
      end
    end
  end

endmodule

// ==== verilog/decodeStage.sv ====
module decodeStage import edgePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  ifIdT    ifId,
  input  wordT    readValueA,
  input  wordT    readValueB,
  output regAddrT readAddrA,
  output regAddrT readAddrB,
  input  logic    stallD,
  input  logic    flushE,
  input  logic    dataStall,
  output idExT    idEx
);

  opcodeT op;
  funcT   func;
  ctrlT   ctrl;
  wordT   imm;

  assign op   = opcodeT'(ifId.instr[31:26]);
  assign func = funcT'(ifId.instr[5:0]);

  // The register file is read with the rs and rt fields in this cycle
  assign readAddrA = ifId.instr[25:21];
  assign readAddrB = ifId.instr[20:16];

  // Only ori takes a zero-extended immediate
  assign imm = (op == OP_ORI) ? {16'h0000, ifId.instr[15:0]} :
                                {{16{ifId.instr[15]}}, ifId.instr[15:0]};

  ////////////////////////////////////////////////////////////////////////////
  // Control decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl = '0;
    ctrl.memSize = MEM_WORD;
    case (op)
      OP_SPECIAL: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (func)
          FN_ADD:  ctrl.aluOp = ALU_ADD;
          FN_SUB:  ctrl.aluOp = ALU_SUB;
          FN_AND:  ctrl.aluOp = ALU_AND;
          FN_OR:   ctrl.aluOp = ALU_OR;
          FN_SLT:  ctrl.aluOp = ALU_SLT;
          FN_SLL:  ctrl.shiftOp = SHIFT_SLL;
          FN_SRL:  ctrl.shiftOp = SHIFT_SRL;
          // Unknown function codes write nothing
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      OP_ADDI, OP_ORI, OP_LUI: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = (op == OP_ADDI) ? ALU_ADD : (op == OP_ORI) ? ALU_OR : ALU_LUI;
      end
      OP_LB, OP_LBU, OP_LW: begin
        ctrl.regWrite   = 1'b1;
        ctrl.memRead    = 1'b1;
        ctrl.resultSel  = RES_MEM;
        ctrl.aluSrcImm  = 1'b1;
        ctrl.loadSigned = (op == OP_LB);
        ctrl.memSize    = (op == OP_LW) ? MEM_WORD : MEM_BYTE;
      end
      OP_SB, OP_SW: begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memSize   = (op == OP_SW) ? MEM_WORD : MEM_BYTE;
      end
      OP_BEQ, OP_BNE: begin
        // The ALU subtracts and the zero flag decides the branch
        ctrl.branch   = 1'b1;
        ctrl.branchNe = (op == OP_BNE);
        ctrl.aluOp    = ALU_SUB;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.link      = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.resultSel = RES_LINK;
      end
      default: ctrl.memSize = MEM_WORD;
    endcase
    // An empty IF/ID slot decodes to a no-op
    if (!ifId.valid) begin
      ctrl = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx <= '0;
    end else if (!dataStall) begin
      if (flushE) begin
        idEx <= '0;
      end else if (!stallD) begin
        idEx.ctrl      <= ctrl;
        idEx.rs        <= readAddrA;
        idEx.rt        <= readAddrB;
        idEx.rd        <= ifId.instr[15:11];
        idEx.rsValue   <= readValueA;
        idEx.rtValue   <= readValueB;
        idEx.imm       <= imm;
        idEx.shamt     <= ifId.instr[10:6];
        idEx.jumpIndex <= ifId.instr[25:0];
        idEx.pcPlus4   <= ifId.pcPlus4;
        idEx.valid     <= ifId.valid;
      end
    end
  end

endmodule

// ==== verilog/fetchStage.sv ====
module fetchStage import edgePkg::*; #(
  parameter wordT resetPc = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rstN,
  input  wordT  instr,
  input  pcSrcT pcSrc,
  input  wordT  branchTarget,
  input  wordT  jumpTarget,
  input  logic  stallF,
  input  logic  stallD,
  input  logic  flushD,
  input  logic  dataStall,
  output wordT  pc,
  output ifIdT  ifId
);

  wordT pcPlus4, pcNext;
  logic redirect, pcEn;

  assign pcPlus4  = pc + 32'd4;
  assign redirect = (pcSrc != PC_PLUS4);

  always_comb begin
    case (pcSrc)
      PC_BRANCH: pcNext = branchTarget;
      PC_JUMP:   pcNext = jumpTarget;
      default:   pcNext = pcPlus4;
    endcase
  end

  // A redirect overrides a load-use hold, but nothing moves while the data
  // port is stalled since the branch is still waiting in the memory stage
  assign pcEn = !dataStall && (redirect || !stallF);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (pcEn) begin
      pc <= pcNext;
    end
  end

  // IF/ID register
  // Flush beats hold, so a fetched word behind a taken branch is dropped
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifId <= '0;
    end else if (!dataStall) begin
      if (flushD) begin
        ifId <= '0;
      end else if (!stallD) begin
        ifId.instr   <= instr;
        ifId.pcPlus4 <= pcPlus4;
        ifId.valid   <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/regFile.sv ====
module regFile import edgePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  regAddrT readAddrA,
  input  regAddrT readAddrB,
  input  regAddrT writeAddr,
  input  logic    writeEn,
  input  wordT    writeValue,
  output wordT    readValueA,
  output wordT    readValueB
);

  wordT regs [32];

  // Register 0 reads as zero, and a write in this cycle is seen at once so
  // decode never picks up a value that writeback is just replacing
  function automatic wordT readPort(regAddrT addr);
    if (addr == '0) begin
      return '0;
    end else if (writeEn && writeAddr == addr) begin
      return writeValue;
    end
    return regs[addr];
  endfunction

  always_comb begin
    readValueA = readPort(readAddrA);
    readValueB = readPort(readAddrB);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeValue;
    end
  end

endmodule

// ==== verilog/edgePkg.sv ====
package edgePkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;

  // Register that jal writes its return address into
  localparam regAddrT LINK_REG = 5'd31;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes sit in bits 31 to 26 of the instruction word
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDI    = 6'h08,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_SB      = 6'h28,
    OP_SW      = 6'h2b
  } opcodeT;

  // Function codes of the special opcode live in bits 5 to 0
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funcT;

  ////////////////////////////////////////////////////////////////////////////
  // Decoded control fields
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} aluOpT;
  typedef enum logic [1:0] {SHIFT_NONE, SHIFT_SLL, SHIFT_SRL} shiftOpT;

  // Same numbering as the reference size field, with the halfword code unused
  typedef enum logic [1:0] {MEM_BYTE = 2'd0, MEM_WORD = 2'd2} memSizeT;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_LINK} resultSelT;
  typedef enum logic [1:0] {FWD_RF, FWD_WB, FWD_MEM} fwdSelT;
  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP} pcSrcT;

  // An all-zero value of this struct behaves as a no-op
  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      memRead;
    resultSelT resultSel;
    aluOpT     aluOp;
    shiftOpT   shiftOp;
    logic      aluSrcImm;
    logic      regDst;
    logic      branch;
    logic      branchNe;
    logic      jump;
    logic      link;
    logic      loadSigned;
    memSizeT   memSize;
  } ctrlT;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline register payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    wordT instr;
    wordT pcPlus4;
    logic valid;
  } ifIdT;

  typedef struct packed {
    ctrlT        ctrl;
    regAddrT     rs;
    regAddrT     rt;
    regAddrT     rd;
    wordT        rsValue;
    wordT        rtValue;
    wordT        imm;
    logic [4:0]  shamt;
    logic [25:0] jumpIndex;
    wordT        pcPlus4;
    logic        valid;
  } idExT;

  typedef struct packed {
    ctrlT    ctrl;
    regAddrT writeReg;
    wordT    aluResult;
    wordT    storeData;
    wordT    branchTarget;
    wordT    jumpTarget;
    logic    zero;
    wordT    pcPlus4;
    logic    valid;
  } exMemT;

  typedef struct packed {
    ctrlT       ctrl;
    regAddrT    writeReg;
    wordT       aluResult;
    wordT       readData;
    logic [1:0] byteLane;
    wordT       pcPlus4;
    logic       valid;
  } memWbT;

endpackage
